//--- design/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Register and immediate data
`define XLEN 32

// Fetch address, matches the 16-bit program memory
`define PC_W 16

// Register file index
`define REG_AW 5

`endif

//--- design/rv_decode_pkg.sv
`include "rv_decode_macros.svh"

package rv_decode_pkg;

   // Base integer opcodes handled by decode
   typedef enum logic [6:0] {
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111
   } opcode_e;

   // ALU_ADD must stay zero, the bubble relies on it
   typedef enum logic [2:0] {
      ALU_ADD     = 3'd0,
      ALU_SUB     = 3'd1,
      ALU_AND     = 3'd2,
      ALU_OR      = 3'd3,
      ALU_XOR     = 3'd4,
      ALU_SLT     = 3'd5,
      ALU_SHIFT_L = 3'd6,
      ALU_SHIFT_R = 3'd7
   } alu_op_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       alu_src;    // Immediate as operand B
      logic       mem_read;
      logic       mem_write;
      logic       reg_write;
      logic [2:0] mem_size;   // funct3 of loads and stores
      logic       jal;
      logic       jalr;
      logic       lui;
      logic       auipc;
   } dec_ctrl_t;

   // Results coming back from the younger stages
   typedef struct packed {
      logic               reg_write;
      logic               mem_read;
      logic [`REG_AW-1:0] rd;
      logic [`XLEN-1:0]   alu_res;
   } ex_mem_fwd_t;

   typedef struct packed {
      logic               reg_write;
      logic [`REG_AW-1:0] rd;
      logic [`XLEN-1:0]   wb_res;
   } mem_wb_fwd_t;

   typedef struct packed {
      dec_ctrl_t          ctrl;
      logic [`REG_AW-1:0] rs1;
      logic [`REG_AW-1:0] rs2;
      logic [`REG_AW-1:0] rd;
      logic [`XLEN-1:0]   op_a;
      logic [`XLEN-1:0]   op_b;
      logic [`XLEN-1:0]   imm;
      logic [`PC_W-1:0]   pc;
   } id_ex_t;

endpackage

//--- design/decode_control.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_control
   import rv_decode_pkg::*;
(
   input  logic               bus,
   input  logic               rst_n,
   input  logic [`XLEN-1:0]   ins,
   input  logic               hold,
   input  logic               id_ex_mem_read,
   input  logic [`REG_AW-1:0] id_ex_rd_fb,
   input  logic               rs1_match_ex,
   input  logic               rs2_match_ex,
   input  logic [1:0]         mem_read_hit,
   input  logic               branch_taken,
   output dec_ctrl_t          ctrl,
   output logic               is_branch,
   output logic               stall,
   output logic               squash
);

   opcode_e    opc;
   logic [2:0] funct3;
   logic       use_rs1;
   logic       use_rs2;
   logic       ex_rd_live;
   logic       load_use;
   logic       branch_hz;

   function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic sub);
      alu_op_e op;
      case (f3)
         3'b000:  op = sub ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SHIFT_L;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLT;
         3'b100:  op = ALU_XOR;
         3'b101:  op = ALU_SHIFT_R;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   assign opc    = opcode_e'(ins[6:0]);
   assign funct3 = ins[14:12];

   ////////////////////////////////////////////////////////////////////////////
   // Main decoder
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      ctrl      = '0;
      is_branch = 1'b0;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
      case (opc)
         OPC_LOAD: begin
            ctrl.alu_src   = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.mem_size  = funct3;
            use_rs1        = 1'b1;
         end
         OPC_STORE: begin
            ctrl.alu_src   = 1'b1;
            ctrl.mem_write = 1'b1;
            ctrl.mem_size  = funct3;
            use_rs1        = 1'b1;
            use_rs2        = 1'b1;
         end
         OPC_OP_IMM: begin
            // No SUBI, bit 30 belongs to the immediate here
            ctrl.alu_op    = funct_to_alu(funct3, 1'b0);
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
            use_rs1        = 1'b1;
         end
         OPC_OP: begin
            ctrl.alu_op    = funct_to_alu(funct3, ins[30]);
            ctrl.reg_write = 1'b1;
            use_rs1        = 1'b1;
            use_rs2        = 1'b1;
         end
         OPC_BRANCH: begin
            ctrl.alu_op = ALU_SUB;
            is_branch   = 1'b1;
            use_rs1     = 1'b1;
            use_rs2     = 1'b1;
         end
         OPC_JAL: begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.jal       = 1'b1;
         end
         OPC_JALR: begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.jalr      = 1'b1;
            use_rs1        = 1'b1;
         end
         OPC_LUI: begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.lui       = 1'b1;
         end
         OPC_AUIPC: begin
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.auipc     = 1'b1;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Hazard detection
   ////////////////////////////////////////////////////////////////////////////

   // ID/EX rd is zeroed when nothing is written, so nonzero implies reg_write
   assign ex_rd_live = (id_ex_rd_fb != '0);

   assign load_use = id_ex_mem_read && ex_rd_live &&
                     ((use_rs1 && rs1_match_ex) || (use_rs2 && rs2_match_ex));

   // Branches resolve here, so their operands must be final now
   assign branch_hz = (is_branch || ctrl.jalr) &&
                      ((use_rs1 && ((ex_rd_live && rs1_match_ex) || mem_read_hit[0])) ||
                       (use_rs2 && ((ex_rd_live && rs2_match_ex) || mem_read_hit[1])));

   // A squashed slot is dropped anyway
   assign stall = !squash && (load_use || branch_hz);

   // Kill the slot behind a taken branch
   always_ff @(posedge bus or negedge rst_n) begin
      if (!rst_n) begin
         squash <= 1'b0;
      end else if (!hold) begin
         squash <= branch_taken;
      end
   end

   a_no_branch_when_blocked: assert property (
      @(posedge bus) disable iff (!rst_n)
      (stall || squash) |-> !branch_taken
   );

   a_squash_one_cycle: assert property (
      @(posedge bus) disable iff (!rst_n)
      (squash && !hold) |=> !squash
   );

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module imm_gen
   import rv_decode_pkg::*;
(
   input  logic [`XLEN-1:0] ins,
   output logic [`XLEN-1:0] imm
);

   opcode_e opc;

   assign opc = opcode_e'(ins[6:0]);

   // Sign bit is always ins[31]
   always_comb begin
      case (opc)
         OPC_LOAD, OPC_OP_IMM, OPC_JALR:
            imm = {{20{ins[31]}}, ins[31:20]};
         OPC_STORE:
            imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         OPC_BRANCH:
            imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         OPC_LUI, OPC_AUIPC:
            imm = {ins[31:12], 12'h000};
         OPC_JAL:
            imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         default:
            imm = '0;
      endcase
   end

endmodule

//--- design/operand_forward.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module operand_forward
   import rv_decode_pkg::*;
(
   input  logic               bus,
   input  logic               rst_n,
   input  logic [`REG_AW-1:0] rs1_addr,
   input  logic [`REG_AW-1:0] rs2_addr,
   input  logic [`XLEN-1:0]   rf_rs1_data,
   input  logic [`XLEN-1:0]   rf_rs2_data,
   input  ex_mem_fwd_t        ex_mem,
   input  mem_wb_fwd_t        mem_wb,
   input  logic [`REG_AW-1:0] id_ex_rd_fb,
   output logic [`XLEN-1:0]   op_a,
   output logic [`XLEN-1:0]   op_b,
   output logic               rs1_match_ex,
   output logic               rs2_match_ex,
   output logic [1:0]         mem_read_hit
);

   // EX/MEM first, then MEM/WB, then the register file
   function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] rs,
                                             input logic [`XLEN-1:0]   rf_val,
                                             input ex_mem_fwd_t        em,
                                             input mem_wb_fwd_t        mw);
      logic [`XLEN-1:0] val;
      if (em.reg_write && !em.mem_read && em.rd != '0 && em.rd == rs) begin
         val = em.alu_res;
      end else if (mw.reg_write && mw.rd != '0 && mw.rd == rs) begin
         val = mw.wb_res;
      end else begin
         val = rf_val;
      end
      return val;
   endfunction

   assign op_a = pick(rs1_addr, rf_rs1_data, ex_mem, mem_wb);
   assign op_b = pick(rs2_addr, rf_rs2_data, ex_mem, mem_wb);

   // Raw compare, the hazard logic qualifies it with rd != 0
   assign rs1_match_ex = (id_ex_rd_fb == rs1_addr);
   assign rs2_match_ex = (id_ex_rd_fb == rs2_addr);

   // Load data in EX/MEM is not ready yet
   assign mem_read_hit[0] = ex_mem.mem_read && ex_mem.rd != '0 && ex_mem.rd == rs1_addr;
   assign mem_read_hit[1] = ex_mem.mem_read && ex_mem.rd != '0 && ex_mem.rd == rs2_addr;

   a_x0_not_forwarded: assert property (
      @(posedge bus) disable iff (!rst_n)
      ((rs1_addr == '0) |-> (op_a == rf_rs1_data)) and
      ((rs2_addr == '0) |-> (op_b == rf_rs2_data))
   );

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module branch_unit
   import rv_decode_pkg::*;
(
   input  logic [`XLEN-1:0] ins,
   input  logic [`PC_W-1:0] pc,
   input  logic [`XLEN-1:0] op_a,
   input  logic [`XLEN-1:0] op_b,
   input  logic [`XLEN-1:0] imm,
   input  dec_ctrl_t        ctrl,
   input  logic             is_branch,
   input  logic             stall,
   input  logic             squash,
   output logic             branch_taken,
   output logic [`PC_W-1:0] branch_target
);

   logic [2:0]       funct3;
   logic             cond;
   logic [`XLEN-1:0] jalr_sum;

   assign funct3 = ins[14:12];

   ////////////////////////////////////////////////////////////////////////////
   // Condition on the forwarded operands
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (funct3)
         3'b000:  cond = (op_a == op_b);
         3'b001:  cond = (op_a != op_b);
         3'b100:  cond = ($signed(op_a) < $signed(op_b));
         3'b101:  cond = ($signed(op_a) >= $signed(op_b));
         3'b110:  cond = (op_a < op_b);
         3'b111:  cond = (op_a >= op_b);
         default: cond = 1'b0;
      endcase
   end

   // Stalled operands are stale, squashed slots are dead
   assign branch_taken = !stall && !squash &&
                         (ctrl.jal || ctrl.jalr || (is_branch && cond));

   ////////////////////////////////////////////////////////////////////////////
   // Target address
   ////////////////////////////////////////////////////////////////////////////

   assign jalr_sum = op_a + imm;

   always_comb begin
      if (ctrl.jalr) begin
         branch_target = {jalr_sum[`PC_W-1:1], 1'b0};
      end else begin
         // B or J immediate, wraps inside the fetch space
         branch_target = pc + imm[`PC_W-1:0];
      end
   end

endmodule

//--- design/id_ex_reg.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module id_ex_reg
   import rv_decode_pkg::*;
(
   input  logic   bus,
   input  logic   rst_n,
   input  logic   hold,
   input  logic   stall,
   input  logic   squash,
   input  id_ex_t next,
   output id_ex_t id_ex
);

   id_ex_t bubble;

   // NOP slot, only the fetch address survives
   always_comb begin
      bubble              = '0;
      bubble.ctrl.alu_src = 1'b1;
      bubble.pc           = next.pc;
   end

   ////////////////////////////////////////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= '0;
      end else if (!hold) begin
         if (stall || squash) begin
            id_ex <= bubble;
         end else begin
            id_ex <= next;
         end
      end
   end

   // Nothing may reach the register file or memory from a bubble
   a_bubble_is_inert: assert property (
      @(posedge bus) disable iff (!rst_n)
      (!hold && (stall || squash)) |=> (!id_ex.ctrl.reg_write && !id_ex.ctrl.mem_write)
   );

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_stage
   import rv_decode_pkg::*;
(
   input  logic               bus,
   input  logic               rst_n,
   input  logic [`XLEN-1:0]   ins,
   input  logic [`PC_W-1:0]   pc,
   input  logic [`XLEN-1:0]   rf_rs1_data,
   input  logic [`XLEN-1:0]   rf_rs2_data,
   input  ex_mem_fwd_t        ex_mem,
   input  mem_wb_fwd_t        mem_wb,
   input  logic               id_ex_mem_read,
   input  logic [`REG_AW-1:0] id_ex_rd_fb,
   input  logic               hold,
   output logic [`REG_AW-1:0] rs1_addr,
   output logic [`REG_AW-1:0] rs2_addr,
   output logic               stall,
   output logic               branch_taken,
   output logic [`PC_W-1:0]   branch_target,
   output id_ex_t             id_ex
);

   dec_ctrl_t        ctrl;
   logic             is_branch;
   logic             squash;
   logic [`XLEN-1:0] imm;
   logic [`XLEN-1:0] op_a;
   logic [`XLEN-1:0] op_b;
   logic             rs1_match_ex;
   logic             rs2_match_ex;
   logic [1:0]       mem_read_hit;
   id_ex_t           next;

   assign rs1_addr = ins[19:15];
   assign rs2_addr = ins[24:20];

   // Bundle for ID/EX, rd kept only for register writers
   assign next.ctrl = ctrl;
   assign next.rs1  = rs1_addr;
   assign next.rs2  = rs2_addr;
   assign next.rd   = ctrl.reg_write ? ins[11:7] : '0;
   assign next.op_a = op_a;
   assign next.op_b = op_b;
   assign next.imm  = imm;
   assign next.pc   = pc;

   decode_control i_decode_control (
      .bus            (bus),
      .rst_n          (rst_n),
      .ins            (ins),
      .hold           (hold),
      .id_ex_mem_read (id_ex_mem_read),
      .id_ex_rd_fb    (id_ex_rd_fb),
      .rs1_match_ex   (rs1_match_ex),
      .rs2_match_ex   (rs2_match_ex),
      .mem_read_hit   (mem_read_hit),
      .branch_taken   (branch_taken),
      .ctrl           (ctrl),
      .is_branch      (is_branch),
      .stall          (stall),
      .squash         (squash)
   );

   imm_gen i_imm_gen (
      .ins (ins),
      .imm (imm)
   );

   operand_forward i_operand_forward (
      .bus          (bus),
      .rst_n        (rst_n),
      .rs1_addr     (rs1_addr),
      .rs2_addr     (rs2_addr),
      .rf_rs1_data  (rf_rs1_data),
      .rf_rs2_data  (rf_rs2_data),
      .ex_mem       (ex_mem),
      .mem_wb       (mem_wb),
      .id_ex_rd_fb  (id_ex_rd_fb),
      .op_a         (op_a),
      .op_b         (op_b),
      .rs1_match_ex (rs1_match_ex),
      .rs2_match_ex (rs2_match_ex),
      .mem_read_hit (mem_read_hit)
   );

   branch_unit i_branch_unit (
      .ins           (ins),
      .pc            (pc),
      .op_a          (op_a),
      .op_b          (op_b),
      .imm           (imm),
      .ctrl          (ctrl),
      .is_branch     (is_branch),
      .stall         (stall),
      .squash        (squash),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   id_ex_reg i_id_ex_reg (
      .bus    (bus),
      .rst_n  (rst_n),
      .hold   (hold),
      .stall  (stall),
      .squash (squash),
      .next   (next),
      .id_ex  (id_ex)
   );

endmodule

//--- sim/decode_stage_tb.sv
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module decode_stage_tb
   import rv_decode_pkg::*;
();

   logic               bus;
   logic               rst_n;
   logic               hold;
   logic [`XLEN-1:0]   ins;
   logic [`PC_W-1:0]   pc;
   logic [`XLEN-1:0]   rf_rs1_data;
   logic [`XLEN-1:0]   rf_rs2_data;
   ex_mem_fwd_t        ex_mem;
   mem_wb_fwd_t        mem_wb;
   logic               id_ex_mem_read;
   logic [`REG_AW-1:0] id_ex_rd_fb;
   logic [`REG_AW-1:0] rs1_addr;
   logic [`REG_AW-1:0] rs2_addr;
   logic               stall;
   logic               branch_taken;
   logic [`PC_W-1:0]   branch_target;
   id_ex_t             id_ex;

   // Expected decode of the instruction on ins
   dec_ctrl_t          e_ctrl;
   logic [`XLEN-1:0]   e_imm;
   logic [`REG_AW-1:0] e_rs1;
   logic [`REG_AW-1:0] e_rs2;
   logic [`REG_AW-1:0] e_rd;
   logic [2:0]         e_f3;
   logic               e_use1;
   logic               e_use2;
   logic               e_br;

   // Reference model state
   logic             m_stall;
   logic             m_taken;
   logic             m_squash;
   logic             m_cond;
   logic             load_use;
   logic             branch_hz;
   logic [`XLEN-1:0] jalr_sum;
   logic [`PC_W-1:0] m_target;
   id_ex_t           m_next;
   id_ex_t           m_bubble;
   id_ex_t           m_id_ex;

   logic [31:0] lfsr;
   int          cycles;
   int          n_load_use;
   int          n_taken;
   int          n_squash;
   int          n_hold;
   int          n_fwd_em;
   int          n_fwd_mw;

   // ID/EX feedback comes from the DUT's own register
   assign id_ex_mem_read = id_ex.ctrl.mem_read;
   assign id_ex_rd_fb    = id_ex.rd;

   decode_stage i_decode_stage (
      .bus            (bus),
      .rst_n          (rst_n),
      .ins            (ins),
      .pc             (pc),
      .rf_rs1_data    (rf_rs1_data),
      .rf_rs2_data    (rf_rs2_data),
      .ex_mem         (ex_mem),
      .mem_wb         (mem_wb),
      .id_ex_mem_read (id_ex_mem_read),
      .id_ex_rd_fb    (id_ex_rd_fb),
      .hold           (hold),
      .rs1_addr       (rs1_addr),
      .rs2_addr       (rs2_addr),
      .stall          (stall),
      .branch_taken   (branch_taken),
      .branch_target  (branch_target),
      .id_ex          (id_ex)
   );

   initial begin
      bus = 1'b0;
      forever #10 bus = ~bus;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois form with taps 32 30 26 25
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   task automatic rnd(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic pick_data(output logic [31:0] v);
      logic [31:0] sel;
      rnd(2, sel);
      case (sel[1:0])
         2'd0:    v = 32'h0000_0000;
         2'd1:    v = 32'hFFFF_FFF0;
         2'd2:    v = 32'h0000_0010;
         default: rnd(32, v);
      endcase
   endtask

   function automatic alu_op_e alu_for(input logic [2:0] f3, input logic sub);
      case (f3)
         3'd0:    return sub ? ALU_SUB : ALU_ADD;
         3'd1:    return ALU_SHIFT_L;
         3'd2:    return ALU_SLT;
         3'd3:    return ALU_SLT;
         3'd4:    return ALU_XOR;
         3'd5:    return ALU_SHIFT_R;
         3'd6:    return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   function automatic logic em_fwd(input logic [`REG_AW-1:0] rs, input ex_mem_fwd_t em);
      return em.reg_write && !em.mem_read && em.rd != '0 && em.rd == rs;
   endfunction

   function automatic logic mw_fwd(input logic [`REG_AW-1:0] rs, input mem_wb_fwd_t mw);
      return mw.reg_write && mw.rd != '0 && mw.rd == rs;
   endfunction

   function automatic logic ld_hit(input logic [`REG_AW-1:0] rs, input ex_mem_fwd_t em);
      return em.mem_read && em.rd != '0 && em.rd == rs;
   endfunction

   task automatic report_mismatch(input string name, input logic [255:0] got,
                                  input logic [255:0] exp);
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus with one random instruction per cycle
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_cycle();
      logic [31:0] r;
      logic [31:0] w;
      logic [31:0] im;
      logic [31:0] d;
      logic [31:0] s1;
      logic [31:0] s2;
      logic [31:0] f;
      logic [31:0] x;
      logic [31:0] v1;
      logic [31:0] v2;
      dec_ctrl_t   c;
      logic        u1;
      logic        u2;
      logic        br;
      c  = '0;
      u1 = 1'b0;
      u2 = 1'b0;
      br = 1'b0;
      rnd(3, d);
      rnd(3, s1);
      rnd(3, s2);
      rnd(3, f);
      rnd(20, x);
      rnd(4, r);
      case (r % 10)
         0: begin
            // Bit 30 only for SUB and SRA
            w = {1'b0, (f[2:0] == 3'd0 || f[2:0] == 3'd5) & x[0], 5'b0, 2'b0, s2[2:0],
                 2'b0, s1[2:0], f[2:0], 2'b0, d[2:0], 7'b0110011};
            im = '0;
            c.alu_op = alu_for(f[2:0], w[30]);
            c.reg_write = 1'b1;
            u1 = 1'b1;
            u2 = 1'b1;
         end
         1, 2, 7: begin
            w = {x[11:0], 2'b0, s1[2:0], f[2:0], 2'b0, d[2:0], 7'b0000011};
            im = {{20{x[11]}}, x[11:0]};
            c.alu_src = 1'b1;
            c.reg_write = 1'b1;
            u1 = 1'b1;
            if (r % 10 == 1) begin
               w[6:0] = 7'b0010011;
               c.alu_op = alu_for(f[2:0], 1'b0);
            end else if (r % 10 == 2) begin
               c.mem_read = 1'b1;
               c.mem_size = f[2:0];
            end else begin
               w[6:0] = 7'b1100111;
               w[14:12] = 3'b000;
               c.jalr = 1'b1;
            end
         end
         3: begin
            w = {x[11:5], 2'b0, s2[2:0], 2'b0, s1[2:0], f[2:0], x[4:0], 7'b0100011};
            im = {{20{x[11]}}, x[11:0]};
            c.alu_src = 1'b1;
            c.mem_write = 1'b1;
            c.mem_size = f[2:0];
            u1 = 1'b1;
            u2 = 1'b1;
         end
         4, 5: begin
            // Funct3 2 and 3 are no branches and fold onto beq and bne
            if (f[2:1] == 2'b01) f[2:1] = 2'b00;
            w = {x[12], x[10:5], 2'b0, s2[2:0], 2'b0, s1[2:0], f[2:0], x[4:1], x[11],
                 7'b1100011};
            im = {{19{x[12]}}, x[12:1], 1'b0};
            c.alu_op = ALU_SUB;
            br = 1'b1;
            u1 = 1'b1;
            u2 = 1'b1;
         end
         6: begin
            w = {x[19], x[9:0], x[10], x[18:11], 2'b0, d[2:0], 7'b1101111};
            im = {{11{x[19]}}, x[19:0], 1'b0};
            c.alu_src = 1'b1;
            c.reg_write = 1'b1;
            c.jal = 1'b1;
         end
         default: begin
            w = {x[19:0], 2'b0, d[2:0], (r % 10 == 8) ? 7'b0110111 : 7'b0010111};
            im = {x[19:0], 12'h000};
            c.alu_src = 1'b1;
            c.reg_write = 1'b1;
            c.lui = (r % 10 == 8);
            c.auipc = (r % 10 != 8);
         end
      endcase
      ins    <= w;
      e_imm  <= im;
      e_ctrl <= c;
      e_use1 <= u1;
      e_use2 <= u2;
      e_br   <= br;
      e_f3   <= w[14:12];
      e_rs1  <= w[19:15];
      e_rs2  <= w[24:20];
      e_rd   <= w[11:7];
      rnd(16, r);
      pc <= r[15:0];
      pick_data(v1);
      pick_data(v2);
      rf_rs1_data <= v1;
      rf_rs2_data <= v2;
      rnd(5, r);
      pick_data(v1);
      ex_mem <= '{reg_write: r[0], mem_read: r[1], rd: {2'b0, r[4:2]}, alu_res: v1};
      rnd(4, r);
      pick_data(v2);
      mem_wb <= '{reg_write: r[0], rd: {2'b0, r[3:1]}, wb_res: v2};
      rnd(3, r);
      hold <= (r[2:0] == 3'd0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model from the forwarding, stall and branch rules
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      load_use = id_ex_mem_read && id_ex_rd_fb != '0 &&
                 ((e_use1 && id_ex_rd_fb == e_rs1) || (e_use2 && id_ex_rd_fb == e_rs2));
      branch_hz = (e_br || e_ctrl.jalr) &&
                  ((e_use1 && ((id_ex_rd_fb != '0 && id_ex_rd_fb == e_rs1) ||
                               ld_hit(e_rs1, ex_mem))) ||
                   (e_use2 && ((id_ex_rd_fb != '0 && id_ex_rd_fb == e_rs2) ||
                               ld_hit(e_rs2, ex_mem))));
      m_stall = !m_squash && (load_use || branch_hz);
      m_next.ctrl = e_ctrl;
      m_next.rs1  = e_rs1;
      m_next.rs2  = e_rs2;
      m_next.rd   = e_ctrl.reg_write ? e_rd : '0;
      m_next.op_a = em_fwd(e_rs1, ex_mem) ? ex_mem.alu_res :
                    mw_fwd(e_rs1, mem_wb) ? mem_wb.wb_res : rf_rs1_data;
      m_next.op_b = em_fwd(e_rs2, ex_mem) ? ex_mem.alu_res :
                    mw_fwd(e_rs2, mem_wb) ? mem_wb.wb_res : rf_rs2_data;
      m_next.imm  = e_imm;
      m_next.pc   = pc;
      case (e_f3)
         3'd0:    m_cond = m_next.op_a == m_next.op_b;
         3'd1:    m_cond = m_next.op_a != m_next.op_b;
         3'd4:    m_cond = $signed(m_next.op_a) < $signed(m_next.op_b);
         3'd5:    m_cond = $signed(m_next.op_a) >= $signed(m_next.op_b);
         3'd6:    m_cond = m_next.op_a < m_next.op_b;
         3'd7:    m_cond = m_next.op_a >= m_next.op_b;
         default: m_cond = 1'b0;
      endcase
      m_taken = !m_stall && !m_squash && (e_ctrl.jal || e_ctrl.jalr || (e_br && m_cond));
      jalr_sum = m_next.op_a + e_imm;
      m_target = e_ctrl.jalr ? {jalr_sum[`PC_W-1:1], 1'b0} : pc + e_imm[`PC_W-1:0];
      m_bubble = '0;
      m_bubble.ctrl.alu_src = 1'b1;
      m_bubble.pc = pc;
   end

   always_ff @(posedge bus or negedge rst_n) begin
      if (!rst_n) begin
         m_id_ex  <= '0;
         m_squash <= 1'b0;
      end else if (!hold) begin
         m_squash <= m_taken;
         m_id_ex  <= (m_stall || m_squash) ? m_bubble : m_next;
      end
   end

   // Coverage of the interesting cases
   always @(posedge bus) begin
      if (rst_n) begin
         if (load_use && m_stall && !hold) n_load_use++;
         if (m_taken && !hold) n_taken++;
         if (m_squash && !hold) n_squash++;
         if (hold) n_hold++;
         if (em_fwd(e_rs1, ex_mem)) n_fwd_em++;
         if (!em_fwd(e_rs1, ex_mem) && mw_fwd(e_rs1, mem_wb)) n_fwd_mw++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   a_reset_id_ex: assert property (@(posedge bus) !rst_n |-> id_ex == '0)
      else report_mismatch("id_ex", 256'($sampled(id_ex)), '0);

   a_reset_stall: assert property (@(posedge bus) !rst_n |-> !stall)
      else report_mismatch("stall", 256'($sampled(stall)), '0);

   a_reset_taken: assert property (@(posedge bus) !rst_n |-> !branch_taken)
      else report_mismatch("branch_taken", 256'($sampled(branch_taken)), '0);

   a_id_ex: assert property (@(posedge bus) disable iff (!rst_n) id_ex == m_id_ex)
      else report_mismatch("id_ex", 256'($sampled(id_ex)), 256'($sampled(m_id_ex)));

   a_hold: assert property (@(posedge bus) disable iff (!rst_n) hold |=> $stable(id_ex))
      else abort_run("id_ex changed while hold was high");

   a_stall: assert property (@(posedge bus) disable iff (!rst_n) stall == m_stall)
      else report_mismatch("stall", 256'($sampled(stall)), 256'($sampled(m_stall)));

   a_taken: assert property (@(posedge bus) disable iff (!rst_n) branch_taken == m_taken)
      else report_mismatch("branch_taken", 256'($sampled(branch_taken)),
                           256'($sampled(m_taken)));

   a_target: assert property (@(posedge bus) disable iff (!rst_n)
      (e_br || e_ctrl.jal || e_ctrl.jalr) |-> branch_target == m_target)
      else report_mismatch("branch_target", 256'($sampled(branch_target)),
                           256'($sampled(m_target)));

   a_rs1_addr: assert property (@(posedge bus) disable iff (!rst_n) rs1_addr == e_rs1)
      else report_mismatch("rs1_addr", 256'($sampled(rs1_addr)), 256'($sampled(e_rs1)));

   a_rs2_addr: assert property (@(posedge bus) disable iff (!rst_n) rs2_addr == e_rs2)
      else report_mismatch("rs2_addr", 256'($sampled(rs2_addr)), 256'($sampled(e_rs2)));

   initial begin
      lfsr        = 32'ha56caf32;
      rst_n       = 1'b0;
      hold        = 1'b0;
      ins         = '0;
      pc          = '0;
      rf_rs1_data = '0;
      rf_rs2_data = '0;
      ex_mem      = '0;
      mem_wb      = '0;
      e_ctrl      = '0;
      e_imm       = '0;
      e_rs1       = '0;
      e_rs2       = '0;
      e_rd        = '0;
      e_f3        = '0;
      e_use1      = 1'b0;
      e_use2      = 1'b0;
      e_br        = 1'b0;
      cycles      = 0;
      repeat (5) @(posedge bus);
      rst_n <= 1'b1;
      // Idle cycle so the post-reset state is seen first
      @(posedge bus);
      while (cycles < 2000 || n_load_use == 0 || n_taken == 0 || n_squash == 0 ||
             n_hold == 0 || n_fwd_em == 0 || n_fwd_mw == 0) begin
         @(posedge bus);
         drive_cycle();
         cycles++;
         if (cycles > 20000) abort_run("timeout waiting for every case to be reached");
      end
      // Let the checks of the last edge settle
      @(posedge bus);
      @(negedge bus);
      $display("Test OK");
      $finish;
   end

endmodule

//--- rv_decode.f
+incdir+design
design/rv_decode_pkg.sv
design/decode_control.sv
design/imm_gen.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/decode_stage.sv
sim/decode_stage_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := decode_stage_tb
FILELIST   := rv_decode.f
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
